/* hdl/eth_frame_pkg.sv */
package eth_frame_pkg;

// ------------------------------------------------------------
// GMII line format
// ------------------------------------------------------------
localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;   // Repeated before the SFD
localparam logic [7:0]  SFD_BYTE      = 8'hd5;   // Start-of-frame delimiter
localparam int unsigned PREAMBLE_LEN  = 7;       // Preamble bytes ahead of the SFD

// ------------------------------------------------------------
// CRC-32, reflected form, LSB of each byte first
// ------------------------------------------------------------
localparam logic [31:0] CRC_INIT    = 32'hffff_ffff;
localparam logic [31:0] CRC_POLY    = 32'hedb8_8320;   // 04C11DB7 bit-reversed
// Running CRC once the FCS of a good frame has been folded in
localparam logic [31:0] CRC_RESIDUE = 32'hdebb_20e3;

// Next CRC after one byte, no final inversion
function automatic logic [31:0] crc32_byte(
    input logic [31:0] crc,
    input logic [7:0]  data
);
    logic [31:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
        if (c[0] ^ data[i]) begin
            c = (c >> 1) ^ CRC_POLY;     // Feedback tap
        end else begin
            c = c >> 1;
        end
    end
    return c;
endfunction

endpackage

/* hdl/rx_queue_pkg.sv */
package rx_queue_pkg;

// Frame length field, counts bytes after the SFD including the FCS
localparam int BYTE_COUNT_W = 12;

// One queue word, earlier byte in [15:8]
typedef logic [15:0] rx_word_t;

// ------------------------------------------------------------
// Per-frame status record, one per frame in the status queue
// ------------------------------------------------------------
typedef struct packed {
    logic [7:0]              spare;          // Always zero
    logic                    overflow;       // Word queue dropped a pair
    logic                    line_err;       // rx_err seen during the frame
    logic                    preamble_err;   // Bad preamble count or SFD
    logic                    crc_err;        // FCS mismatch
    logic [7:0]              first_byte;     // First byte after the SFD
    logic [BYTE_COUNT_W-1:0] byte_count;
} rx_status_t;

// Frame goes to the flush path if any error flag is up
function automatic logic status_bad(input rx_status_t s);
    return s.crc_err | s.preamble_err | s.line_err | s.overflow;
endfunction

endpackage

/* hdl/rx_preamble_strip.sv */
`timescale 1ns/100ps

module rx_preamble_strip
    import eth_frame_pkg::*;
(
    input  logic       RxClk,
    input  logic       rst_n,
    input  logic       rx_valid,       // GMII RX_DV
    input  logic [7:0] rx_data,        // GMII RXD
    input  logic       rx_err,         // GMII RX_ER
    output logic       byte_valid,     // One pulse per data byte
    output logic [7:0] byte_data,
    output logic       frame_start,    // With the first data byte
    output logic       frame_end,      // Cycle after the last data byte
    output logic       preamble_err,   // Held until frame_end
    output logic       line_err
);

logic       in_frame;     // SFD position passed, forwarding data
logic [3:0] pre_cnt;      // Preamble bytes seen, saturates
logic       first_pend;   // Next data byte is the first one

// ------------------------------------------------------------
// Hunt for SFD, then forward bytes until RX_DV drops
// ------------------------------------------------------------
always_ff @(posedge RxClk or negedge rst_n) begin
    if (!rst_n) begin
        in_frame     <= 1'b0;
        pre_cnt      <= 4'd0;
        first_pend   <= 1'b0;
        byte_valid   <= 1'b0;
        frame_start  <= 1'b0;
        frame_end    <= 1'b0;
        preamble_err <= 1'b0;
        line_err     <= 1'b0;
    end else begin
        byte_valid  <= 1'b0;       // Strobes default low
        frame_start <= 1'b0;
        frame_end   <= 1'b0;
        if (!in_frame) begin
            if (!rx_valid) begin
                pre_cnt <= 4'd0;   // Gap restarts the hunt
            end else if (rx_data == PREAMBLE_BYTE) begin
                if (pre_cnt != 4'hf)
                    pre_cnt <= pre_cnt + 4'd1;
            end else begin
                // First non-preamble byte stands in the SFD slot
                in_frame     <= 1'b1;
                first_pend   <= 1'b1;
                pre_cnt      <= 4'd0;
                preamble_err <= (rx_data != SFD_BYTE) || (pre_cnt != 4'(PREAMBLE_LEN));
                line_err     <= rx_err;
            end
        end else if (rx_valid) begin
            byte_valid  <= 1'b1;
            frame_start <= first_pend;
            first_pend  <= 1'b0;
            line_err    <= line_err | rx_err;   // Sticky over the frame
        end else begin
            frame_end <= 1'b1;     // RX_DV dropped
            in_frame  <= 1'b0;
        end
    end
end

// Data path register
always_ff @(posedge RxClk) begin
    if (rx_valid)
        byte_data <= rx_data;
end

endmodule

/* hdl/rx_frame_check.sv */
`timescale 1ns/100ps

module rx_frame_check
    import eth_frame_pkg::*;
    import rx_queue_pkg::*;
(
    input  logic       RxClk,
    input  logic       rst_n,
    input  logic       byte_valid,
    input  logic [7:0] byte_data,
    input  logic       frame_start,
    input  logic       frame_end,
    input  logic       preamble_err,
    input  logic       line_err,
    output logic       pass_valid,     // byte_valid, one cycle later
    output logic [7:0] pass_data,
    output logic       status_valid,   // Cycle after frame_end
    output rx_status_t frame_status
);

logic [31:0]             crc;          // Running CRC incl. FCS
logic [BYTE_COUNT_W-1:0] byte_cnt;     // Bytes after SFD
logic [7:0]              first_byte;

// ------------------------------------------------------------
// CRC and byte count, reloaded on frame_start
// ------------------------------------------------------------
always_ff @(posedge RxClk or negedge rst_n) begin
    if (!rst_n) begin
        pass_valid   <= 1'b0;
        status_valid <= 1'b0;
        crc          <= CRC_INIT;
        byte_cnt     <= '0;
    end else begin
        pass_valid   <= byte_valid;
        status_valid <= frame_end;
        if (byte_valid) begin
            crc      <= crc32_byte(frame_start ? CRC_INIT : crc, byte_data);
            byte_cnt <= frame_start ? BYTE_COUNT_W'(1) : byte_cnt + 1'b1;
        end else if (frame_end) begin
            crc      <= CRC_INIT;   // Empty frame then reads as a CRC error
            byte_cnt <= '0;
        end
    end
end

// Payload and status record
always_ff @(posedge RxClk) begin
    pass_data <= byte_data;
    if (byte_valid && frame_start)
        first_byte <= byte_data;
    if (frame_end) begin
        frame_status.spare        <= '0;
        frame_status.overflow     <= 1'b0;          // Filled in by the packer
        frame_status.line_err     <= line_err;
        frame_status.preamble_err <= preamble_err;
        frame_status.crc_err      <= (crc != CRC_RESIDUE);
        frame_status.first_byte   <= first_byte;
        frame_status.byte_count   <= byte_cnt;
    end
end

endmodule

/* hdl/rx_word_pack.sv */
`timescale 1ns/100ps

module rx_word_pack
    import rx_queue_pkg::*;
(
    input  logic       RxClk,
    input  logic       rst_n,
    input  logic       pass_valid,
    input  logic [7:0] pass_data,
    input  logic       status_valid,
    input  rx_status_t frame_status,
    input  logic       word_full,
    input  logic       status_full,
    output logic       word_push,
    output rx_word_t   word_data,
    output logic       status_push,
    output rx_status_t status_data
);

logic       half_full;   // High byte waiting for its pair
logic [7:0] high_byte;
logic       ovf;         // Pair dropped somewhere in this frame

// ------------------------------------------------------------
// Pair bytes, push words, close the frame with its status
// ------------------------------------------------------------
always_ff @(posedge RxClk or negedge rst_n) begin
    if (!rst_n) begin
        half_full   <= 1'b0;
        ovf         <= 1'b0;
        word_push   <= 1'b0;
        status_push <= 1'b0;
    end else begin
        word_push   <= 1'b0;
        status_push <= 1'b0;
        // status_valid and pass_valid never share a cycle
        if (status_valid) begin
            word_push   <= half_full & ~word_full;   // Odd tail, padded
            status_push <= ~status_full;   // Dropped status leaves its words queued
            half_full   <= 1'b0;
            ovf         <= 1'b0;
        end else if (pass_valid) begin
            if (!half_full) begin
                half_full <= 1'b1;
            end else begin
                half_full <= 1'b0;
                word_push <= ~word_full;
                if (word_full)
                    ovf <= 1'b1;         // Pair lost, flag the frame
            end
        end
    end
end

// Word and record payloads
always_ff @(posedge RxClk) begin
    if (pass_valid && !half_full)
        high_byte <= pass_data;
    if (status_valid) begin
        word_data            <= {high_byte, 8'h00};    // Zero low half
        status_data          <= frame_status;
        status_data.overflow <= ovf | (half_full & word_full);
    end else if (pass_valid && half_full) begin
        word_data <= {high_byte, pass_data};   // Earlier byte high
    end
end

endmodule

/* hdl/rx_sync_fifo.sv */
`timescale 1ns/100ps

module rx_sync_fifo #(
    parameter type T     = logic [15:0],
    parameter int  DEPTH = 16             // Power of two, 2 or more
) (
    input  logic RxClk,
    input  logic rst_n,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     head,                    // Oldest entry, shown without a pop
    output logic empty,
    output logic full
);

localparam int AW = $clog2(DEPTH);

T            mem [DEPTH];
logic [AW:0] wr_ptr;     // Extra MSB tells full from empty
logic [AW:0] rd_ptr;
logic        wr_en;
logic        rd_en;

assign wr_en = push & ~full;
assign rd_en = pop & ~empty;    // Pop of an empty queue does nothing

assign empty = (wr_ptr == rd_ptr);
assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
assign head  = mem[rd_ptr[AW-1:0]];   // Fall-through read

// ------------------------------------------------------------
// Pointers
// ------------------------------------------------------------
always_ff @(posedge RxClk or negedge rst_n) begin
    if (!rst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
    end else begin
        if (wr_en)
            wr_ptr <= wr_ptr + 1'b1;
        if (rd_en)
            rd_ptr <= rd_ptr + 1'b1;
    end
end

// Storage
always_ff @(posedge RxClk) begin
    if (wr_en)
        mem[wr_ptr[AW-1:0]] <= push_data;
end

endmodule

/* hdl/rx_frame_reader.sv */
`timescale 1ns/100ps

module rx_frame_reader
    import rx_queue_pkg::*;
(
    input  logic        RxClk,
    input  logic        rst_n,
    input  rx_status_t  status_head,
    input  logic        status_empty,
    input  rx_word_t    word_head,
    input  logic        word_empty,
    input  logic        recv_busy,      // Host has taken the frame
    output logic        status_pop,
    output logic        word_pop,
    output logic        recv_request,   // Level, good frame waiting
    output rx_status_t  recv_status,
    output logic        recv_ready,     // One pulse per word
    output rx_word_t    recv_word,
    output logic [15:0] good_frames,
    output logic [15:0] bad_frames
);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ_WAIT,
    ST_DELIVER,
    ST_FLUSH
} rd_state_t;

rd_state_t               state;
logic [BYTE_COUNT_W-1:0] words_left;    // Words still queued for this frame
logic [1:0]              phase;         // Word cadence, 0..2
logic [BYTE_COUNT_W-1:0] frame_words;

// Bytes rounded up to whole words
assign frame_words = {1'b0, status_head.byte_count[BYTE_COUNT_W-1:1]}
                   + status_head.byte_count[0];

assign recv_word = word_head;   // Head is valid while recv_ready is up

// ------------------------------------------------------------
// Frame FSM
// ------------------------------------------------------------
always_ff @(posedge RxClk or negedge rst_n) begin
    if (!rst_n) begin
        state        <= ST_IDLE;
        words_left   <= '0;
        phase        <= 2'd0;
        status_pop   <= 1'b0;
        word_pop     <= 1'b0;
        recv_request <= 1'b0;
        recv_ready   <= 1'b0;
        good_frames  <= 16'd0;
        bad_frames   <= 16'd0;
    end else begin
        status_pop <= 1'b0;
        word_pop   <= 1'b0;
        recv_ready <= 1'b0;
        case (state)
        ST_IDLE: begin
            phase <= 2'd0;
            if (!status_empty) begin
                status_pop <= 1'b1;            // Record latched below
                words_left <= frame_words;
                if (status_bad(status_head)) begin
                    bad_frames <= bad_frames + 16'd1;
                    state      <= ST_FLUSH;
                end else begin
                    good_frames  <= good_frames + 16'd1;
                    recv_request <= 1'b1;
                    state        <= ST_REQ_WAIT;
                end
            end
        end
        ST_REQ_WAIT: begin
            if (recv_busy) begin               // Host acknowledged
                recv_request <= 1'b0;
                state        <= ST_DELIVER;
            end
        end
        ST_DELIVER: begin
            if (words_left == '0) begin
                state <= ST_IDLE;
            end else if (recv_busy) begin      // Busy low freezes the cadence
                if (phase == 2'd0) begin
                    if (!word_empty) begin
                        recv_ready <= 1'b1;
                        word_pop   <= 1'b1;     // Same cycle as the ready pulse
                        words_left <= words_left - 1'b1;
                        phase      <= 2'd1;
                    end
                end else begin
                    phase <= (phase == 2'd2) ? 2'd0 : phase + 2'd1;
                end
            end
        end
        ST_FLUSH: begin
            // One pop per cycle, stops early if the queue runs dry
            if (words_left == '0 || word_empty) begin
                state <= ST_IDLE;
            end else begin
                word_pop   <= 1'b1;
                words_left <= words_left - 1'b1;
            end
        end
        default: state <= ST_IDLE;
        endcase
    end
end

// Status shown to the host
always_ff @(posedge RxClk) begin
    if (state == ST_IDLE && !status_empty)
        recv_status <= status_head;
end

endmodule

/* hdl/gmii_rx_top.sv */
`timescale 1ns/100ps

module gmii_rx_top
    import rx_queue_pkg::*;
#(
    parameter int WORD_DEPTH   = 1024,   // Words, several frames deep
    parameter int STATUS_DEPTH = 8       // Frames
) (
    input  logic        RxClk,
    input  logic        rst_n,
    input  logic        rx_valid,
    input  logic [7:0]  rx_data,
    input  logic        rx_err,
    input  logic        recv_busy,
    output logic        recv_request,
    output rx_status_t  recv_status,
    output logic        recv_ready,
    output rx_word_t    recv_word,
    output logic [15:0] good_frames,
    output logic [15:0] bad_frames
);

// ------------------------------------------------------------
// Stage wiring
// ------------------------------------------------------------
logic       byte_valid, frame_start, frame_end, preamble_err, line_err;
logic [7:0] byte_data;
logic       pass_valid, status_valid;
logic [7:0] pass_data;
rx_status_t frame_status;
logic       word_push, status_push, word_pop, status_pop;
rx_word_t   word_data, word_head;
rx_status_t status_data, status_head;
logic       word_full, word_empty, status_full, status_empty;

rx_preamble_strip u_strip (
    .RxClk, .rst_n, .rx_valid, .rx_data, .rx_err,
    .byte_valid, .byte_data, .frame_start, .frame_end, .preamble_err, .line_err
);

rx_frame_check u_check (
    .RxClk, .rst_n, .byte_valid, .byte_data, .frame_start, .frame_end,
    .preamble_err, .line_err, .pass_valid, .pass_data, .status_valid, .frame_status
);

rx_word_pack u_pack (
    .RxClk, .rst_n, .pass_valid, .pass_data, .status_valid, .frame_status,
    .word_full, .status_full, .word_push, .word_data, .status_push, .status_data
);

// Word queue, frame data
rx_sync_fifo #(.T(rx_word_t), .DEPTH(WORD_DEPTH)) u_word_fifo (
    .RxClk, .rst_n, .push(word_push), .push_data(word_data), .pop(word_pop),
    .head(word_head), .empty(word_empty), .full(word_full)
);

// Status queue, one record per frame
rx_sync_fifo #(.T(rx_status_t), .DEPTH(STATUS_DEPTH)) u_status_fifo (
    .RxClk, .rst_n, .push(status_push), .push_data(status_data), .pop(status_pop),
    .head(status_head), .empty(status_empty), .full(status_full)
);

rx_frame_reader u_reader (
    .RxClk, .rst_n, .status_head, .status_empty, .word_head, .word_empty, .recv_busy,
    .status_pop, .word_pop, .recv_request, .recv_status, .recv_ready, .recv_word,
    .good_frames, .bad_frames
);

endmodule

/* dv/tb_frame_table.svh */
`ifndef TB_FRAME_TABLE_SVH
`define TB_FRAME_TABLE_SVH

// Columns: payload length, preamble count, bad SFD, bad FCS, rx_err mid-frame,
// busy drop after word n (0 = none), hold until the next frame is sent, expected good
typedef struct packed {
    int len;
    int pre_cnt;
    bit bad_sfd;
    bit bad_fcs;
    bit err_mid;
    int drop_at;
    bit hold;
    bit good;
} frame_entry_t;

localparam int NUM_FRAMES = 12;

frame_entry_t frame_table [NUM_FRAMES] = '{
    '{46, 7, 1'b0, 1'b0, 1'b0, 0, 1'b0, 1'b1},   // Even byte count
    '{47, 7, 1'b0, 1'b0, 1'b0, 0, 1'b0, 1'b1},   // Odd byte count, padded tail
    '{50, 7, 1'b0, 1'b1, 1'b0, 0, 1'b0, 1'b0},   // FCS corrupted
    '{40, 7, 1'b0, 1'b0, 1'b0, 0, 1'b0, 1'b1},   // Good right after a flush
    '{48, 5, 1'b0, 1'b0, 1'b0, 0, 1'b0, 1'b0},   // Short preamble
    '{44, 7, 1'b1, 1'b0, 1'b0, 0, 1'b0, 1'b0},   // Bad SFD
    '{52, 7, 1'b0, 1'b0, 1'b1, 0, 1'b0, 1'b0},   // rx_err mid-frame
    '{61, 7, 1'b0, 1'b0, 1'b0, 0, 1'b0, 1'b1},
    '{60, 7, 1'b0, 1'b0, 1'b0, 0, 1'b1, 1'b1},   // Queued, host stays away
    '{45, 7, 1'b0, 1'b0, 1'b0, 0, 1'b0, 1'b1},   // Second of the back-to-back pair
    '{64, 7, 1'b0, 1'b0, 1'b0, 5, 1'b0, 1'b1},   // Host stalls after word 5
    '{49, 7, 1'b0, 1'b0, 1'b0, 1, 1'b0, 1'b1}    // Stall after the first word
};

// Payload generator, 32-bit xorshift
function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// Reflected CRC-32 step over one byte, used to build the FCS
function automatic logic [31:0] crc32_update(input logic [31:0] crc, input logic [7:0] data);
    logic [31:0] c;
    c = crc ^ {24'h0, data};
    for (int k = 0; k < 8; k++) begin
        c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
    end
    return c;
endfunction

`endif

/* dv/tb_gmii_rx.sv */
`timescale 1ns/100ps

module tb_gmii_rx
    import eth_frame_pkg::*;
    import rx_queue_pkg::*;
();

localparam int IFG_CYCLES   = 12;     // Idle gap after each frame
localparam int DROP_CYCLES  = 6;      // Length of a host stall
localparam int REQ_TIMEOUT  = 2000;
localparam int WORD_TIMEOUT = 40;
localparam int BAD_TIMEOUT  = 1000;
localparam int MAX_BYTES    = 128;

`include "tb_frame_table.svh"

logic        RxClk;
logic        rst_n;
logic        rx_valid;
logic [7:0]  rx_data;
logic        rx_err;
logic        recv_busy;
logic        recv_request;
rx_status_t  recv_status;
logic        recv_ready;
rx_word_t    recv_word;
logic [15:0] good_frames;
logic [15:0] bad_frames;

int          errors          = 0;
int          checks          = 0;
int          exp_good        = 0;
int          exp_bad         = 0;
int          exp_words_total = 0;
int          ready_pulses    = 0;   // Every recv_ready seen over the run
bit          aborted         = 1'b0;
logic [31:0] seed;
logic [7:0]  frame_bytes [NUM_FRAMES][MAX_BYTES];   // Bytes after the SFD including the FCS
int          frame_size [NUM_FRAMES];
int          pending [$];                           // Sent and not yet served

gmii_rx_top #(.WORD_DEPTH(1024), .STATUS_DEPTH(8)) u_gmii_rx_top (
    .RxClk, .rst_n, .rx_valid, .rx_data, .rx_err, .recv_busy,
    .recv_request, .recv_status, .recv_ready, .recv_word, .good_frames, .bad_frames
);

initial RxClk = 1'b0;
always #50 RxClk = ~RxClk;          // 100 ns period

always @(negedge RxClk) begin
    if (recv_ready === 1'b1)
        ready_pulses <= ready_pulses + 1;
end

// ------------------------------------------------------------
// Checks
// ------------------------------------------------------------
task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
        $display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
        errors++;
    end
endtask

task automatic check_true(input logic ok, input string what);
    checks++;
    assert (ok === 1'b1) else begin
        $display("ERROR at %0t ns: %s", $time, what);
        errors++;
    end
endtask

// ------------------------------------------------------------
// GMII driver with one byte per falling edge
// ------------------------------------------------------------
task automatic drive_byte(input logic [7:0] data, input logic err);
    @(negedge RxClk);
    rx_valid = 1'b1;
    rx_data  = data;
    rx_err   = err;
endtask

task automatic drive_idle(input int n);
    repeat (n) begin
        @(negedge RxClk);
        rx_valid = 1'b0;
        rx_data  = 8'h00;
        rx_err   = 1'b0;
    end
endtask

task automatic send_frame(input int idx);
    frame_entry_t e;
    logic [31:0]  crc;
    logic [7:0]   b;
    e   = frame_table[idx];
    crc = 32'hffff_ffff;
    for (int i = 0; i < e.len; i++) begin
        seed = xorshift32(seed);
        b    = seed[7:0];
        frame_bytes[idx][i] = b;
        crc  = crc32_update(crc, b);
    end
    crc = ~crc;                                        // FCS goes out inverted and LSB first
    for (int i = 0; i < 4; i++)
        frame_bytes[idx][e.len + i] = crc[8 * i +: 8];
    if (e.bad_fcs)
        frame_bytes[idx][e.len] = frame_bytes[idx][e.len] ^ 8'h01;
    frame_size[idx] = e.len + 4;
    for (int i = 0; i < e.pre_cnt; i++)
        drive_byte(PREAMBLE_BYTE, 1'b0);
    drive_byte(e.bad_sfd ? 8'hc5 : SFD_BYTE, 1'b0);
    for (int i = 0; i < frame_size[idx]; i++)
        drive_byte(frame_bytes[idx][i], e.err_mid && (i == e.len / 2));
    drive_idle(IFG_CYCLES);
endtask

// ------------------------------------------------------------
// Host model
// ------------------------------------------------------------
task automatic receive_good(input int idx);
    int          cycles;
    int          n_words;
    int          got;
    bit          stalled;
    logic [7:0]  low_byte;
    logic [15:0] exp_word;
    n_words = (frame_size[idx] + 1) / 2;                // Odd tail rounds up
    exp_good++;
    exp_words_total += n_words;
    cycles = 0;
    while (!recv_request && cycles < REQ_TIMEOUT) begin
        @(negedge RxClk);
        cycles++;
    end
    if (!recv_request) begin
        $display("Timeout at %0t ns: frame %0d never raised recv_request", $time, idx);
        aborted = 1'b1;
        return;
    end
    check_value("recv_status.byte_count", 32'(recv_status.byte_count), 32'(frame_size[idx]));
    check_value("recv_status.first_byte", 32'(recv_status.first_byte),
                32'(frame_bytes[idx][0]));
    check_value("recv_status error flags", 32'({recv_status.crc_err, recv_status.preamble_err,
                recv_status.line_err, recv_status.overflow}), 32'h0);
    check_value("recv_status.spare", 32'(recv_status.spare), 32'h0);
    check_value("good_frames", 32'(good_frames), 32'(exp_good));
    recv_busy = 1'b1;                                   // Take the frame
    got       = 0;
    stalled   = 1'b1;                                   // No spacing check on the first word
    while (got < n_words && !aborted) begin
        cycles = 0;
        do begin
            @(negedge RxClk);
            cycles++;
        end while (!recv_ready && cycles < WORD_TIMEOUT);
        if (!recv_ready) begin
            $display("Timeout at %0t ns: frame %0d stopped after %0d of %0d words",
                     $time, idx, got, n_words);
            aborted = 1'b1;
        end else begin
            low_byte = (2 * got + 1 < frame_size[idx]) ? frame_bytes[idx][2 * got + 1] : 8'h00;
            exp_word = {frame_bytes[idx][2 * got], low_byte};   // Earlier byte high
            check_value("recv_word", 32'(recv_word), 32'(exp_word));
            if (!stalled)
                check_value("recv_ready spacing", cycles, 3);
            stalled = 1'b0;
            got++;
            if (got == frame_table[idx].drop_at && got < n_words) begin
                recv_busy = 1'b0;                       // Host back-pressure
                repeat (DROP_CYCLES) begin
                    @(negedge RxClk);
                    check_true(!recv_ready, "recv_ready pulsed while recv_busy was low");
                end
                recv_busy = 1'b1;
                stalled   = 1'b1;
            end
        end
    end
    recv_busy = 1'b0;
endtask

task automatic expect_bad(input int idx);
    int cycles;
    exp_bad++;
    cycles = 0;
    while (int'(bad_frames) != exp_bad && cycles < BAD_TIMEOUT) begin
        @(negedge RxClk);
        cycles++;
    end
    if (int'(bad_frames) != exp_bad) begin
        $display("Timeout at %0t ns: frame %0d was never counted as bad", $time, idx);
        aborted = 1'b1;
    end else begin
        check_true(!recv_request, "recv_request raised for a frame that should be dropped");
        check_value("good_frames", 32'(good_frames), 32'(exp_good));
    end
endtask

task automatic serve_frame(input int idx);
    int errors_before;
    errors_before = errors;
    if (frame_table[idx].good)
        receive_good(idx);
    else
        expect_bad(idx);
    $display("frame %0d: %0d payload bytes, expected %s, %s", idx, frame_table[idx].len,
             frame_table[idx].good ? "good" : "bad",
             aborted ? "timed out" : ((errors == errors_before) ? "ok" : "mismatch"));
endtask

// ------------------------------------------------------------
// Main sequence
// ------------------------------------------------------------
initial begin
    int idx;
    seed      = 32'hbfec;
    rst_n     = 1'b0;
    rx_valid  = 1'b0;
    rx_data   = 8'h00;
    rx_err    = 1'b0;
    recv_busy = 1'b0;
    repeat (3) @(negedge RxClk);
    rst_n = 1'b1;
    check_value("recv_request", 32'(recv_request), 32'h0);   // Reset state
    check_value("recv_ready", 32'(recv_ready), 32'h0);
    check_value("good_frames", 32'(good_frames), 32'h0);
    check_value("bad_frames", 32'(bad_frames), 32'h0);

    for (int t = 0; t < NUM_FRAMES && !aborted; t++) begin
        send_frame(t);
        pending.push_back(t);
        if (!frame_table[t].hold) begin
            while (pending.size() > 0 && !aborted) begin
                idx = pending.pop_front();
                serve_frame(idx);
            end
        end
    end

    if (!aborted) begin
        drive_idle(20);
        check_value("recv_ready pulse count", 32'(ready_pulses), 32'(exp_words_total));
        check_value("good_frames", 32'(good_frames), 32'(exp_good));
        check_value("bad_frames", 32'(bad_frames), 32'(exp_bad));
    end

    $display("checks %0d, errors %0d, frames good %0d bad %0d, words %0d",
             checks, errors, exp_good, exp_bad, ready_pulses);
    if (errors == 0 && !aborted)
        $display("TEST PASS");
    else
        $display("TEST FAIL");
    $finish;
end

endmodule

/* filelist.f */
+incdir+dv
hdl/eth_frame_pkg.sv
hdl/rx_queue_pkg.sv
hdl/rx_preamble_strip.sv
hdl/rx_frame_check.sv
hdl/rx_word_pack.sv
hdl/rx_sync_fifo.sv
hdl/rx_frame_reader.sv
hdl/gmii_rx_top.sv
dv/tb_gmii_rx.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the GMII receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_gmii_rx --Mdir "$BUILD_DIR" -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_gmii_rx" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
fi
exit 1
